// File: list.f
verilog/uart_rx_pkg.sv
verilog/apb_slave.sv
verilog/rx_sampler.sv
verilog/rx_controller.sv
verilog/apb_uart_rx.sv
sim/apb_uart_rx_properties.sv
sim/tb_apb_uart_rx.sv

// File: sim/apb_uart_rx_properties.sv
`timescale 1ns/1ns

module apb_uart_rx_properties (
    input logic clk,
    input logic n_rst,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic pslverr,
    input logic data_read,
    input logic data_ready,
    input logic framing_error
);

    int fail_count = 0; // Collected by the testbench at the end of the run

    a_read_no_err: assert property (@(posedge clk) disable iff (!n_rst)
        (psel && penable && !pwrite) |-> !pslverr)
        else begin
            fail_count++;
            $error("pslverr is high during a read access");
        end

    a_read_strobe: assert property (@(posedge clk) disable iff (!n_rst)
        data_read |-> (psel && penable))
        else begin
            fail_count++;
            $error("data_read pulsed outside an APB access cycle");
        end

    // A frame either delivers a word or flags a bad stop bit, never both
    a_ready_or_framing: assert property (@(posedge clk) disable iff (!n_rst)
        !($rose(data_ready) && $rose(framing_error)))
        else begin
            fail_count++;
            $error("data_ready and framing_error rose in the same cycle");
        end

endmodule

bind apb_uart_rx apb_uart_rx_properties u_properties (
    .clk           (clk),
    .n_rst         (n_rst),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pslverr       (pslverr),
    .data_read     (data_read),
    .data_ready    (data_ready),
    .framing_error (framing_error)
);

// File: sim/tb_apb_uart_rx.sv
`timescale 1ns/1ns

module tb_apb_uart_rx import uart_rx_pkg::*; ();

    localparam int NUM_FRAMES = 7;

    typedef struct packed {
        bit_period_t period;
        data_size_t  size;
        byte_t       data;
        logic        stop;
        logic        read_after; // Read the word before the next frame
    } frame_entry_t;

    logic      clk;
    logic      n_rst;
    logic      serial_in;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    byte_t     pwdata;
    byte_t     prdata;
    logic      pslverr;

    frame_entry_t frames [NUM_FRAMES];
    integer       seed;
    int           checks;
    int           errors;
    int           cycles;
    int           cycle_limit;
    byte_t        exp_data;
    logic         exp_ready;
    logic         exp_overrun;
    logic         exp_framing;

    apb_uart_rx #(
        .SYNC_STAGES (2)
    ) u_dut (
        .clk       (clk),
        .n_rst     (n_rst),
        .serial_in (serial_in),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input byte_t actual, input byte_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // paddr stays put after the access, the slave still decodes it in its write state
    task automatic apb_write(input apb_addr_t addr, input byte_t data);
        @(posedge clk);
        #5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #5;
        penable = 1'b1;
        @(posedge clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output byte_t data);
        @(posedge clk);
        #5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #5;
        penable = 1'b1;
        @(negedge clk);
        data = prdata; // prdata is only valid in the access cycle
        @(posedge clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic hold_line(input logic level, input int length);
        @(posedge clk);
        #5;
        serial_in = level;
        repeat (length - 1) @(posedge clk);
    endtask

    task automatic send_frame(input bit_period_t period, input data_size_t size,
                              input byte_t data, input logic stop);
        hold_line(1'b0, period);
        for (int i = 0; i < size; i++) begin
            hold_line(data[i], period);
        end
        hold_line(stop, period);
        hold_line(1'b1, period); // Idle gap so a low stop bit still leaves a start edge
    endtask

    task automatic add_frame(input int idx, input bit_period_t period, input data_size_t size,
                             input logic stop, input logic read_after);
        integer r;
        r = $random(seed);
        frames[idx] = {period, size, r[7:0], stop, read_after};
    endtask

    // Start, data, stop and idle gap of every frame
    function automatic int frame_budget();
        int total;
        total = 0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            total += (frames[i].size + 3) * frames[i].period;
        end
        return 2 * total + 200;
    endfunction

    task automatic check_slave_error(input apb_addr_t addr, input logic expect_err);
        byte_t value;
        apb_write(addr, 8'h5a);
        @(negedge clk);
        compare_value("pslverr", {7'b0, pslverr}, {7'b0, expect_err});
        apb_read(ADDR_DATA_SIZE, value);
        @(negedge clk);
        compare_value("pslverr", {7'b0, pslverr}, 8'd0);
    endtask

    task automatic wait_ready();
        byte_t value;
        int    polls;
        value = '0;
        polls = 0;
        while (value != 8'd1 && polls < 16) begin
            apb_read(ADDR_DATA_STATUS, value);
            polls++;
        end
        if (value != 8'd1) begin
            errors++;
            $display("Data ready was never set after the frame ending at %0t ns", $time);
        end
    endtask

    task automatic collect_word();
        byte_t value;
        if (exp_ready) begin
            wait_ready();
        end else begin
            apb_read(ADDR_DATA_STATUS, value);
            compare_value("data_ready", value, 8'd0);
        end
        apb_read(ADDR_ERROR_STATUS, value);
        compare_value("error_status", value, exp_framing ? 8'd1 : (exp_overrun ? 8'd2 : 8'd0));
        apb_read(ADDR_RX_DATA, value);
        compare_value("rx_data", value, exp_data);
        exp_ready   = 1'b0;
        exp_overrun = 1'b0;
        exp_framing = 1'b0;
        apb_read(ADDR_DATA_STATUS, value);
        compare_value("data_ready", value, 8'd0);
        apb_read(ADDR_ERROR_STATUS, value);
        compare_value("error_status", value, 8'd0);
    endtask

    task automatic apply_frame(input frame_entry_t f);
        byte_t value;
        apb_write(ADDR_BIT_PERIOD_LO, f.period[7:0]);
        apb_write(ADDR_BIT_PERIOD_HI, {2'b0, f.period[13:8]});
        apb_write(ADDR_DATA_SIZE, {4'b0, f.size});
        apb_read(ADDR_BIT_PERIOD_LO, value);
        compare_value("bit_period_lo", value, f.period[7:0]);
        apb_read(ADDR_BIT_PERIOD_HI, value);
        compare_value("bit_period_hi", value, {2'b0, f.period[13:8]});
        apb_read(ADDR_DATA_SIZE, value);
        compare_value("data_size", value, {4'b0, f.size});
        send_frame(f.period, f.size, f.data, f.stop);
        if (f.stop) begin
            exp_overrun = exp_overrun | exp_ready;
            exp_ready   = 1'b1;
            exp_data    = f.data & (8'hff >> (4'd8 - f.size)); // Right-justified word
        end else begin
            exp_framing = 1'b1;
        end
        if (f.read_after) begin
            collect_word();
        end
    endtask

    initial begin
        byte_t value;
        clk         = 1'b0;
        n_rst       = 1'b0;
        serial_in   = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        seed        = 32'h52e14223;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        exp_data    = '0;
        exp_ready   = 1'b0;
        exp_overrun = 1'b0;
        exp_framing = 1'b0;
        add_frame(0, 14'd16, 4'd8, 1'b1, 1'b1);
        add_frame(1, 14'd16, 4'd5, 1'b1, 1'b1);
        add_frame(2, 14'd27, 4'd7, 1'b1, 1'b1);
        add_frame(3, 14'd27, 4'd6, 1'b0, 1'b1); // Bad stop bit
        add_frame(4, 14'd27, 4'd8, 1'b1, 1'b0); // Overrun pair
        add_frame(5, 14'd27, 4'd8, 1'b1, 1'b1);
        add_frame(6, 14'd16, 4'd8, 1'b1, 1'b1);
        cycle_limit = frame_budget();
        repeat (8) @(posedge clk);
        #5;
        n_rst = 1'b1;
        for (int a = 0; a < 8; a++) begin
            apb_read(a[2:0], value);
            compare_value($sformatf("reset value of register %0d", a), value, 8'd0);
        end
        compare_value("pslverr", {7'b0, pslverr}, 8'd0);
        check_slave_error(ADDR_DATA_STATUS, 1'b1);
        check_slave_error(ADDR_ERROR_STATUS, 1'b1);
        check_slave_error(ADDR_RX_DATA, 1'b1);
        check_slave_error(ADDR_BIT_PERIOD_LO, 1'b0);
        check_slave_error(ADDR_BIT_PERIOD_HI, 1'b0); // Leaves a nonzero high byte behind
        for (int i = 0; i < NUM_FRAMES; i++) begin
            apply_frame(frames[i]);
        end
        repeat (4) @(posedge clk);
        errors += u_dut.u_properties.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog/apb_slave.sv
`timescale 1ns/1ns

module apb_slave import uart_rx_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  byte_t       pwdata,
    input  byte_t       rx_data,
    input  logic        data_ready,
    input  logic        overrun_error,
    input  logic        framing_error,
    output byte_t       prdata,
    output logic        pslverr,
    output logic        data_read,
    output bit_period_t bit_period,
    output data_size_t  data_size
);

    typedef enum logic [1:0] {
        idle,
        write,
        read,
        err_idle
    } apb_state_t;

    apb_state_t state, next_state;
    logic       ro_addr;
    logic       wr_access;

    // Status and receive data registers cannot be written
    assign ro_addr = (paddr == ADDR_DATA_STATUS) || (paddr == ADDR_ERROR_STATUS) ||
                     (paddr == ADDR_RX_DATA);

    assign wr_access = (state == write) && penable;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle, err_idle: begin
                if (psel && pwrite) begin
                    next_state = write;
                end else if (psel) begin
                    next_state = read;
                end
            end
            write: begin
                if (ro_addr) begin
                    next_state = err_idle; // Error is reported after the access
                end else if (psel && pwrite) begin
                    next_state = write;
                end else begin
                    next_state = idle;
                end
            end
            read: begin
                if (psel && !pwrite) begin
                    next_state = read;
                end else begin
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    // Configuration registers take the write at the end of the access cycle
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bit_period <= '0;
            data_size  <= '0;
        end else if (wr_access) begin
            case (paddr)
                ADDR_BIT_PERIOD_LO: bit_period[7:0]  <= pwdata;
                ADDR_BIT_PERIOD_HI: bit_period[13:8] <= pwdata[5:0];
                ADDR_DATA_SIZE:     data_size        <= pwdata[3:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        prdata    = '0;
        data_read = 1'b0;
        if (state == read && penable) begin
            case (paddr)
                ADDR_DATA_STATUS: prdata = {7'b0, data_ready};
                ADDR_ERROR_STATUS: begin
                    // Framing error wins when both flags are set
                    if (framing_error) begin
                        prdata = 8'd1;
                    end else if (overrun_error) begin
                        prdata = 8'd2;
                    end
                end
                ADDR_BIT_PERIOD_LO: prdata = bit_period[7:0];
                ADDR_BIT_PERIOD_HI: prdata = {2'b0, bit_period[13:8]};
                ADDR_DATA_SIZE:     prdata = {4'b0, data_size};
                ADDR_RX_DATA: begin
                    prdata    = rx_data;
                    data_read = 1'b1;
                end
                default: prdata = '0;
            endcase
        end
    end

    // Held until the master starts a new transfer
    assign pslverr = (state == err_idle);

endmodule

// File: verilog/apb_uart_rx.sv
`timescale 1ns/1ns

module apb_uart_rx import uart_rx_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      serial_in,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  byte_t     pwdata,
    output byte_t     prdata,
    output logic      pslverr
);

    bit_period_t bit_period;
    data_size_t  data_size;
    byte_t       rx_data;
    logic        data_ready;
    logic        overrun_error;
    logic        framing_error;
    logic        data_read;
    logic        timer_en;
    logic        rx_bit;
    logic        start_edge;
    logic        sample_strobe;

    apb_slave u_apb_slave (
        .clk           (clk),
        .n_rst         (n_rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .rx_data       (rx_data),
        .data_ready    (data_ready),
        .overrun_error (overrun_error),
        .framing_error (framing_error),
        .prdata        (prdata),
        .pslverr       (pslverr),
        .data_read     (data_read),
        .bit_period    (bit_period),
        .data_size     (data_size)
    );

    rx_sampler #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_rx_sampler (
        .clk           (clk),
        .n_rst         (n_rst),
        .serial_in     (serial_in),
        .timer_en      (timer_en),
        .bit_period    (bit_period),
        .rx_bit        (rx_bit),
        .start_edge    (start_edge),
        .sample_strobe (sample_strobe)
    );

    rx_controller u_rx_controller (
        .clk           (clk),
        .n_rst         (n_rst),
        .start_edge    (start_edge),
        .sample_strobe (sample_strobe),
        .rx_bit        (rx_bit),
        .data_size     (data_size),
        .data_read     (data_read),
        .timer_en      (timer_en),
        .rx_data       (rx_data),
        .data_ready    (data_ready),
        .overrun_error (overrun_error),
        .framing_error (framing_error)
    );

endmodule

// File: verilog/rx_controller.sv
`timescale 1ns/1ns

module rx_controller import uart_rx_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       start_edge,
    input  logic       sample_strobe,
    input  logic       rx_bit,
    input  data_size_t data_size,
    input  logic       data_read,
    output logic       timer_en,
    output byte_t      rx_data,
    output logic       data_ready,
    output logic       overrun_error,
    output logic       framing_error
);

    typedef enum logic [1:0] {
        idle,
        start_check,
        data_bits,
        stop_check
    } rx_state_t;

    rx_state_t  state, next_state;
    data_size_t eff_size;
    data_size_t bit_cnt;
    byte_t      shift_q;
    byte_t      word;
    logic       stop_hit;
    logic       load;
    logic       frame_bad;

    // Sizes outside 1 to 8 fall back to a full byte
    assign eff_size = (data_size == 4'd0 || data_size > 4'd8) ? 4'd8 : data_size;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (start_edge) begin
                    next_state = start_check;
                end
            end
            start_check: begin
                if (sample_strobe) begin
                    next_state = rx_bit ? idle : data_bits; // High here is a glitch
                end
            end
            data_bits: begin
                if (sample_strobe && bit_cnt == eff_size - 4'd1) begin
                    next_state = stop_check;
                end
            end
            stop_check: begin
                if (sample_strobe) begin
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    assign timer_en = (state != idle);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bit_cnt <= '0;
        end else if (state != data_bits) begin
            bit_cnt <= '0;
        end else if (sample_strobe) begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    // Bits arrive LSB first and enter from the top
    always_ff @(posedge clk) begin
        if (state == data_bits && sample_strobe) begin
            shift_q <= {rx_bit, shift_q[7:1]};
        end
    end

    assign word = shift_q >> (4'd8 - eff_size);

    assign stop_hit  = (state == stop_check) && sample_strobe;
    assign load      = stop_hit && rx_bit;
    assign frame_bad = stop_hit && !rx_bit;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rx_data <= '0;
        end else if (load) begin
            rx_data <= word;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            data_ready    <= 1'b0;
            overrun_error <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            if (load) begin
                data_ready <= 1'b1;
            end else if (data_read) begin
                data_ready <= 1'b0;
            end
            if (load && data_ready) begin
                overrun_error <= 1'b1;
            end else if (data_read) begin
                overrun_error <= 1'b0;
            end
            if (frame_bad) begin
                framing_error <= 1'b1;
            end else if (data_read) begin
                framing_error <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/rx_sampler.sv
`timescale 1ns/1ns

module rx_sampler import uart_rx_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        serial_in,
    input  logic        timer_en,
    input  bit_period_t bit_period,
    output logic        rx_bit,
    output logic        start_edge,
    output logic        sample_strobe
);

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   rx_bit_prev;
    bit_period_t            count;
    bit_period_t            half_period;

    // The line idles high, so the chain resets high to avoid a false start
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sync_q <= '1;
        end else begin
            sync_q[0] <= serial_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign rx_bit = sync_q[SYNC_STAGES-1];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rx_bit_prev <= 1'b1;
        end else begin
            rx_bit_prev <= rx_bit;
        end
    end

    // Edges inside a frame are data, not start bits
    assign start_edge = !timer_en && rx_bit_prev && !rx_bit;

    assign half_period = bit_period >> 1;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (!timer_en) begin
            count <= half_period; // First strobe lands mid start bit
        end else if (count <= 14'd1) begin
            count <= bit_period;
        end else begin
            count <= count - 14'd1;
        end
    end

    // A period below two still strobes every cycle instead of stalling
    assign sample_strobe = timer_en && (count <= 14'd1);

endmodule

// File: verilog/uart_rx_pkg.sv
package uart_rx_pkg;

    // Bus data and received words are one byte wide
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  apb_addr_t;
    typedef logic [13:0] bit_period_t; // Clock cycles per serial bit
    typedef logic [3:0]  data_size_t;

    // Status registers are read only
    localparam apb_addr_t ADDR_DATA_STATUS  = 3'd0;
    localparam apb_addr_t ADDR_ERROR_STATUS = 3'd1;

    // Configuration registers
    localparam apb_addr_t ADDR_BIT_PERIOD_LO = 3'd2;
    localparam apb_addr_t ADDR_BIT_PERIOD_HI = 3'd3;
    localparam apb_addr_t ADDR_DATA_SIZE     = 3'd4;

    localparam apb_addr_t ADDR_RX_DATA = 3'd6; // Reading it acknowledges the word

endpackage
